// ==== dv/mem_model.sv ====
/*
 testbench memory, every command is taken at once with a rotating tag 1..15
 loads reply after latency cycles, the word at byte address a reads as a ^ 32'h5a5a_0000
*/
`timescale 1ns/100ps
`default_nettype none

module mem_model #(
    parameter int latency = 4
) (
    input  logic                                clock,
    input  logic                                reset,
    input  fetch_pkg::bus_command_t             mem_command,
    input  logic [fetch_pkg::xlen-1:0]          mem_addr,
    input  logic [fetch_pkg::line_width-1:0]    mem_data,
    output logic [fetch_pkg::bus_tag_width-1:0] mem_response,
    output logic [fetch_pkg::bus_tag_width-1:0] mem_tag,
    output logic [fetch_pkg::line_width-1:0]    mem_reply_data
);
    import fetch_pkg::*;

    localparam logic [xlen-1:0] data_pattern = 32'h5a5a_0000;

    logic [bus_tag_width-1:0] next_tag;
    logic [latency-1:0]       pipe_valid;
    logic [bus_tag_width-1:0] pipe_tag  [latency];
    logic [xlen-1:0]          pipe_addr [latency];
    logic [xlen-1:0]          reply_addr;

    // stores are answered too, their data goes nowhere
    assign mem_response = (mem_command != bus_none) ? next_tag : '0;

    // 15 wraps back to 1, tag 0 stays reserved
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            next_tag <= bus_tag_width'(1);
        end else if (mem_command != bus_none) begin
            next_tag <= (next_tag == '1) ? bus_tag_width'(1) : next_tag + bus_tag_width'(1);
        end
    end

    ////////////////////////////////////////
    // fixed latency load pipe
    ////////////////////////////////////////

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            pipe_valid <= '0;
        end else begin
            pipe_valid[0] <= (mem_command == bus_load);
            for (int i = 1; i < latency; i++) begin
                pipe_valid[i] <= pipe_valid[i-1];
            end
        end
    end

    // tag and address ride along, only looked at when valid
    always_ff @(posedge clock) begin
        pipe_tag[0]  <= next_tag;
        pipe_addr[0] <= mem_addr;
        for (int i = 1; i < latency; i++) begin
            pipe_tag[i]  <= pipe_tag[i-1];
            pipe_addr[i] <= pipe_addr[i-1];
        end
    end

    // whole line, lower word at the aligned address
    assign reply_addr     = {pipe_addr[latency-1][xlen-1:3], 3'b000};
    assign mem_tag        = pipe_valid[latency-1] ? pipe_tag[latency-1] : '0;
    assign mem_reply_data = pipe_valid[latency-1]
        ? {(reply_addr + xlen'(4)) ^ data_pattern, reply_addr ^ data_pattern} : '0;

endmodule

`default_nettype wire

// ==== dv/tb_fetch_mem.sv ====
/*
 fetch front end testbench, program stays below byte 256 so no icache line is replaced
 data loads land in 0x1000..0x1ff8 and never touch the icache
*/
`timescale 1ns/100ps
`default_nettype none

module tb_fetch_mem;
    import fetch_pkg::*;

    localparam int mem_latency  = 4;
    localparam int reset_cycles = 8;
    localparam int num_rows     = 16;
    localparam int row_budget   = 40;
    localparam logic [xlen-1:0] data_pattern = 32'h5a5a_0000;
    localparam int action_none   = 0;
    localparam int action_branch = 1;
    localparam int action_load   = 2;

    logic clock = 1'b0;
    logic reset, take_branch, if_id_valid;
    logic [xlen-1:0] branch_target, dmem_addr, mem_addr, if_id_inst, if_id_pc, if_id_npc;
    logic [line_width-1:0] dmem_data, dmem_reply_data, mem_data, mem_reply_data;
    logic [bus_tag_width-1:0] dmem_response, dmem_tag, mem_response, mem_tag;
    bus_command_t dmem_command, mem_command;

    // stimulus table, one action per row, rows in rising cycle order
    int              row_cycle  [num_rows];
    int              row_action [num_rows];
    logic [xlen-1:0] row_addr   [num_rows];

    // scoreboard
    int error_count, fetch_count, reply_count, monitor_cycle;
    logic [xlen-1:0] expected_pc;
    logic [31:0] seen_lines;
    logic [31:0] lcg_state;
    logic [bus_tag_width-1:0] pending_tag [$];
    logic [xlen-1:0] pending_addr [$];

    always #5 clock = ~clock;

    fetch_mem_top #(.num_lines(icache_lines)) dut0 (
        .clock(clock), .reset(reset), .take_branch(take_branch), .branch_target(branch_target),
        .dmem_command(dmem_command), .dmem_addr(dmem_addr), .dmem_data(dmem_data),
        .mem_response(mem_response), .mem_reply_data(mem_reply_data), .mem_tag(mem_tag),
        .if_id_valid(if_id_valid), .if_id_inst(if_id_inst), .if_id_pc(if_id_pc),
        .if_id_npc(if_id_npc), .dmem_response(dmem_response), .dmem_tag(dmem_tag),
        .dmem_reply_data(dmem_reply_data), .mem_command(mem_command), .mem_addr(mem_addr),
        .mem_data(mem_data)
    );

    mem_model #(.latency(mem_latency)) memory0 (
        .clock(clock), .reset(reset), .mem_command(mem_command), .mem_addr(mem_addr),
        .mem_data(mem_data), .mem_response(mem_response), .mem_tag(mem_tag),
        .mem_reply_data(mem_reply_data)
    );

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    // memory contents rule
    function automatic logic [line_width-1:0] line_at(input logic [xlen-1:0] addr);
        logic [xlen-1:0] base;
        base = {addr[xlen-1:3], 3'b000};
        return {(base + 32'd4) ^ data_pattern, base ^ data_pattern};
    endfunction

    task automatic flag_mismatch(input string message);
        error_count++;
        $display("FAILED at %0t: %s", $time, message);
    endtask

    // load rows ignore target and draw an address from the lcg
    task automatic set_row(input int index, input int cycle, input int action,
                           input logic [xlen-1:0] target);
        row_cycle[index]  = cycle;
        row_action[index] = action;
        row_addr[index]   = target;
        if (action == action_load) begin
            lcg_state       = lcg_next(lcg_state);
            row_addr[index] = 32'h0000_1000 + {20'd0, lcg_state[16:8], 3'd0};
        end
    endtask

    ////////////////////////////////////////
    // monitor, samples at the falling edge
    ////////////////////////////////////////

    always @(negedge clock) begin : monitor
        int found;
        if (reset) begin
            if (if_id_valid || mem_command != bus_none) begin
                flag_mismatch("fetch or bus active during reset");
            end
        end else begin
            if (monitor_cycle == 0 && (if_id_valid || mem_command != bus_none)) begin
                flag_mismatch("fetch or bus active right after reset");
            end
            monitor_cycle++;
            // in order fetch, resync on a mismatch to avoid a cascade
            if (if_id_valid) begin
                if (if_id_pc != expected_pc) begin
                    flag_mismatch($sformatf("if_id_pc %h, expected %h", if_id_pc, expected_pc));
                end
                if (if_id_inst != (if_id_pc ^ data_pattern)) begin
                    flag_mismatch($sformatf("if_id_inst %h at pc %h", if_id_inst, if_id_pc));
                end
                if (if_id_npc != if_id_pc + 32'd4) begin
                    flag_mismatch($sformatf("if_id_npc %h at pc %h", if_id_npc, if_id_pc));
                end
                if (if_id_pc < 32'd256) begin
                    seen_lines[if_id_pc[7:3]] = 1'b1;
                end
                expected_pc = if_id_pc + 32'd4;
                fetch_count++;
            end
            // output in the branch cycle is still the old stream
            if (take_branch) begin
                expected_pc = branch_target;
            end
            // a line that already hit must never go back to memory
            if (dmem_command == bus_none && mem_command == bus_load && mem_addr < 32'd256
                    && seen_lines[mem_addr[7:3]]) begin
                flag_mismatch($sformatf("fetch re-requested cached line %h", mem_addr));
            end
            if (dmem_command != bus_none && (mem_addr != dmem_addr
                    || mem_command != dmem_command || mem_data != dmem_data)) begin
                flag_mismatch($sformatf("bus shows %h data %h, data side drives %h data %h",
                                        mem_addr, mem_data, dmem_addr, dmem_data));
            end
            if (dmem_command == bus_load) begin
                if (dmem_response == '0) begin
                    flag_mismatch($sformatf("data load %h got response 0", dmem_addr));
                end else begin
                    pending_tag.push_back(dmem_response);
                    pending_addr.push_back(dmem_addr);
                end
            end
            if (dmem_tag != '0) begin
                found = -1;
                foreach (pending_tag[i]) begin
                    if (found < 0 && pending_tag[i] == dmem_tag) begin
                        found = i;
                    end
                end
                if (found < 0) begin
                    flag_mismatch($sformatf("data reply with unknown tag %0d", dmem_tag));
                end else begin
                    if (dmem_reply_data != line_at(pending_addr[found])) begin
                        flag_mismatch($sformatf("data reply %h for %h", dmem_reply_data,
                                                pending_addr[found]));
                    end
                    pending_tag.delete(found);
                    pending_addr.delete(found);
                    reply_count++;
                end
            end
        end
    end

    ////////////////////////////////////////
    // stimulus and closing report
    ////////////////////////////////////////

    initial begin : stimulus
        int row;
        int cycle_now;
        reset = 1'b1;
        take_branch = 1'b0;
        branch_target = '0;
        dmem_command = bus_none;
        dmem_addr = '0;
        dmem_data = '0;
        error_count = 0;
        fetch_count = 0;
        reply_count = 0;
        monitor_cycle = 0;
        expected_pc = '0;
        seen_lines = '0;
        lcg_state = 32'd88;
        // burst of loads starves fetch, branches go back and forward
        set_row(0, 10, action_load, '0);
        set_row(1, 11, action_load, '0);
        set_row(2, 12, action_load, '0);
        set_row(3, 13, action_load, '0);
        set_row(4, 14, action_load, '0);
        set_row(5, 15, action_load, '0);
        set_row(6, 30, action_branch, 32'h0000_0008);
        set_row(7, 45, action_load, '0);
        set_row(8, 60, action_branch, 32'h0000_0040);
        set_row(9, 62, action_load, '0);
        set_row(10, 75, action_branch, 32'h0000_0004);
        set_row(11, 90, action_load, '0);
        set_row(12, 91, action_load, '0);
        set_row(13, 100, action_branch, 32'h0000_0080);
        set_row(14, 110, action_load, '0);
        set_row(15, 125, action_none, '0);
        repeat (reset_cycles) @(posedge clock);
        reset <= 1'b0;
        cycle_now = 0;
        for (row = 0; row < num_rows; row++) begin
            while (cycle_now < row_cycle[row]) begin
                @(posedge clock);
                cycle_now++;
                take_branch  <= 1'b0;
                dmem_command <= bus_none;
            end
            if (row_action[row] == action_branch) begin
                take_branch   <= 1'b1;
                branch_target <= row_addr[row];
            end else if (row_action[row] == action_load) begin
                dmem_command <= bus_load;
                dmem_addr    <= row_addr[row];
                // write data means nothing to a load but still crosses the bus mux
                dmem_data    <= {row_addr[row], ~row_addr[row]};
            end
        end
        repeat (2 * mem_latency) @(posedge clock);
        if (pending_tag.size() != 0) begin
            error_count++;
            $display("%0d data loads never got a reply", pending_tag.size());
        end
        if (fetch_count < 20) begin
            error_count++;
            $display("fetch stalled, only %0d instructions reached IF/ID", fetch_count);
        end
        $display("fetched %0d  data replies %0d  errors %0d",
                 fetch_count, reply_count, error_count);
        if (error_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    // budget per table row plus reset
    initial begin : watchdog
        repeat (reset_cycles + row_budget * num_rows) @(posedge clock);
        $display("timeout, run did not finish in %0d cycles",
                 reset_cycles + row_budget * num_rows);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
hw/fetch_pkg.sv
hw/fetch_stage.sv
hw/icache.sv
hw/mem_arbiter.sv
hw/fetch_mem_top.sv
dv/mem_model.sv
dv/tb_fetch_mem.sv

// ==== hw/fetch_mem_top.sv ====
/*
 fetch, icache and arbiter on one external memory bus
 the dmem ports stand in for a load/store queue and follow the same bus rules
*/
`timescale 1ns/100ps
`default_nettype none

module fetch_mem_top #(
    parameter int num_lines = fetch_pkg::icache_lines
) (
    input  logic                                clock,
    input  logic                                reset,
    input  logic                                take_branch,
    input  logic [fetch_pkg::xlen-1:0]          branch_target,
    input  fetch_pkg::bus_command_t             dmem_command,
    input  logic [fetch_pkg::xlen-1:0]          dmem_addr,
    input  logic [fetch_pkg::line_width-1:0]    dmem_data,
    input  logic [fetch_pkg::bus_tag_width-1:0] mem_response,
    input  logic [fetch_pkg::line_width-1:0]    mem_reply_data,
    input  logic [fetch_pkg::bus_tag_width-1:0] mem_tag,
    output logic                                if_id_valid,
    output logic [fetch_pkg::xlen-1:0]          if_id_inst,
    output logic [fetch_pkg::xlen-1:0]          if_id_pc,
    output logic [fetch_pkg::xlen-1:0]          if_id_npc,
    output logic [fetch_pkg::bus_tag_width-1:0] dmem_response,
    output logic [fetch_pkg::bus_tag_width-1:0] dmem_tag,
    output logic [fetch_pkg::line_width-1:0]    dmem_reply_data,
    output fetch_pkg::bus_command_t             mem_command,
    output logic [fetch_pkg::xlen-1:0]          mem_addr,
    output logic [fetch_pkg::line_width-1:0]    mem_data
);
    import fetch_pkg::*;

    // fetch to icache
    logic [xlen-1:0]       fetch_addr;
    logic                  icache_valid;
    logic [line_width-1:0] icache_data;

    // icache to arbiter
    bus_command_t             imem_command;
    logic [xlen-1:0]          imem_addr;
    logic [bus_tag_width-1:0] imem_response;
    logic [line_width-1:0]    imem_data;
    logic [bus_tag_width-1:0] imem_tag;

    fetch_stage fetch_stage_0 (
        .clock(clock), .reset(reset),
        .take_branch(take_branch), .branch_target(branch_target),
        .icache_valid(icache_valid), .icache_data(icache_data),
        .fetch_addr(fetch_addr), .if_id_valid(if_id_valid),
        .if_id_inst(if_id_inst), .if_id_pc(if_id_pc), .if_id_npc(if_id_npc)
    );

    icache #(.num_lines(num_lines)) icache_0 (
        .clock(clock), .reset(reset), .fetch_addr(fetch_addr),
        .imem_response(imem_response), .imem_data(imem_data), .imem_tag(imem_tag),
        .icache_valid(icache_valid), .icache_data(icache_data),
        .imem_command(imem_command), .imem_addr(imem_addr)
    );

    mem_arbiter mem_arbiter_0 (
        .clock(clock), .reset(reset),
        .dmem_command(dmem_command), .dmem_addr(dmem_addr), .dmem_data(dmem_data),
        .imem_command(imem_command), .imem_addr(imem_addr),
        .mem_response(mem_response), .mem_reply_data(mem_reply_data), .mem_tag(mem_tag),
        .mem_command(mem_command), .mem_addr(mem_addr), .mem_data(mem_data),
        .dmem_response(dmem_response), .dmem_tag(dmem_tag),
        .dmem_reply_data(dmem_reply_data), .imem_response(imem_response),
        .imem_tag(imem_tag), .imem_data(imem_data)
    );

endmodule

`default_nettype wire

// ==== hw/fetch_pkg.sv ====
/*
 shared bus and cache constants for the fetch front end
 memory lines are 64 bits wide, so each line holds two instructions
*/
`default_nettype none

package fetch_pkg;

    ////////////////////////////////////////
    // widths
    ////////////////////////////////////////

    // address and instruction width
    localparam int xlen = 32;

    // one memory beat, also one cache line
    localparam int line_width = 64;

    // memory tag width, tag 0 means no transaction
    localparam int bus_tag_width = 4;

    ////////////////////////////////////////
    // bus commands
    ////////////////////////////////////////

    // level command, held until a nonzero response comes back
    typedef enum logic [1:0] {
        bus_none  = 2'b00,
        bus_load  = 2'b01,
        bus_store = 2'b10
    } bus_command_t;

    ////////////////////////////////////////
    // cache geometry
    ////////////////////////////////////////

    // default icache depth
    // must stay a power of two, index bits come from $clog2
    localparam int icache_lines = 32;

endpackage

`default_nettype wire

// ==== hw/fetch_stage.sv ====
/*
 branch_target must be word aligned
 icache_data is a full 64-bit line, address bit 2 picks the instruction
*/
`timescale 1ns/100ps
`default_nettype none

module fetch_stage (
    input  logic                             clock,
    input  logic                             reset,
    input  logic                             take_branch,
    input  logic [fetch_pkg::xlen-1:0]       branch_target,
    input  logic                             icache_valid,
    input  logic [fetch_pkg::line_width-1:0] icache_data,
    output logic [fetch_pkg::xlen-1:0]       fetch_addr,
    output logic                             if_id_valid,
    output logic [fetch_pkg::xlen-1:0]       if_id_inst,
    output logic [fetch_pkg::xlen-1:0]       if_id_pc,
    output logic [fetch_pkg::xlen-1:0]       if_id_npc
);
    import fetch_pkg::*;

    logic [xlen-1:0] pc;
    logic [xlen-1:0] pc_plus_4;
    logic [xlen-1:0] fetch_inst;

    ////////////////////////////////////////
    // program counter
    ////////////////////////////////////////

    // cache is looked up with the raw pc every cycle
    assign fetch_addr = pc;
    assign pc_plus_4  = pc + xlen'(4);

    // redirect beats a hit
    // on a miss the pc just sits here until the line shows up
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            pc <= '0;
        end else if (take_branch) begin
            pc <= branch_target;
        end else if (icache_valid) begin
            pc <= pc_plus_4;
        end
    end

    // upper half of the line holds the word at address + 4
    assign fetch_inst = pc[2] ? icache_data[xlen +: xlen] : icache_data[0 +: xlen];

    ////////////////////////////////////////
    // IF/ID register
    ////////////////////////////////////////

    // valid only for a hit that was not squashed by a redirect
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            if_id_valid <= 1'b0;
        end else begin
            if_id_valid <= icache_valid && !take_branch;
        end
    end

    // payload only moves on a hit, otherwise keeps the last value
    always_ff @(posedge clock) begin
        if (icache_valid) begin
            if_id_inst <= fetch_inst;
            if_id_pc   <= pc;
            if_id_npc  <= pc_plus_4;
        end
    end

    // targets come from outside, so check the pc never drifts off a word
    pc_word_aligned: assert property (
        @(posedge clock) disable iff (reset)
        pc[1:0] == 2'b00
    ) else $error("fetch pc not word aligned: %h", pc);

endmodule

`default_nettype wire

// ==== hw/icache.sv ====
/*
 direct mapped, one 64-bit line per entry, a single miss in flight
 a fill whose line no longer matches the fetch address is dropped
*/
`timescale 1ns/100ps
`default_nettype none

module icache #(
    parameter int num_lines = fetch_pkg::icache_lines
) (
    input  logic                                clock,
    input  logic                                reset,
    input  logic [fetch_pkg::xlen-1:0]          fetch_addr,
    input  logic [fetch_pkg::bus_tag_width-1:0] imem_response,
    input  logic [fetch_pkg::line_width-1:0]    imem_data,
    input  logic [fetch_pkg::bus_tag_width-1:0] imem_tag,
    output logic                                icache_valid,
    output logic [fetch_pkg::line_width-1:0]    icache_data,
    output fetch_pkg::bus_command_t             imem_command,
    output logic [fetch_pkg::xlen-1:0]          imem_addr
);
    import fetch_pkg::*;

    // address split: | tag | index | byte offset |
    localparam int offset_bits = $clog2(line_width / 8);
    localparam int index_bits  = $clog2(num_lines);
    localparam int tag_bits    = xlen - index_bits - offset_bits;

    typedef enum logic [1:0] {
        state_idle,
        state_requesting,
        state_waiting
    } miss_state_t;

    // line storage
    logic [num_lines-1:0]  line_valid;
    logic [tag_bits-1:0]   line_tag  [num_lines];
    logic [line_width-1:0] line_data [num_lines];

    logic [index_bits-1:0]    fetch_index;
    logic [tag_bits-1:0]      fetch_tag;
    logic [xlen-1:0]          fetch_line;
    logic                     hit;
    miss_state_t              state;
    miss_state_t              next_state;
    logic [xlen-1:0]          miss_addr;
    logic [bus_tag_width-1:0] miss_tag;
    logic [index_bits-1:0]    miss_index;
    logic                     same_line;
    logic                     accepted;
    logic                     fill_arrive;
    logic                     fill_write;

    ////////////////////////////////////////
    // lookup
    ////////////////////////////////////////

    assign fetch_index = fetch_addr[offset_bits +: index_bits];
    assign fetch_tag   = fetch_addr[xlen-1 -: tag_bits];
    assign fetch_line  = {fetch_addr[xlen-1:offset_bits], {offset_bits{1'b0}}};

    // combinational read, hit shows in the same cycle as the address
    assign hit          = line_valid[fetch_index] && (line_tag[fetch_index] == fetch_tag);
    assign icache_valid = hit;
    assign icache_data  = line_data[fetch_index];

    ////////////////////////////////////////
    // miss handling
    ////////////////////////////////////////

    assign miss_index = miss_addr[offset_bits +: index_bits];
    // redirect check, fetch moved to another line
    assign same_line  = (miss_addr == fetch_line);
    assign accepted   = (state == state_requesting) && (imem_response != '0);
    // miss_tag is never zero, so an idle bus cannot match
    assign fill_arrive = (state == state_waiting) && (imem_tag == miss_tag);
    assign fill_write  = fill_arrive && same_line;

    // request held as a level until the arbiter hands back a tag
    assign imem_command = (state == state_requesting) ? bus_load : bus_none;
    assign imem_addr    = miss_addr;

    always_comb begin
        next_state = state;
        case (state)
            state_idle: begin
                if (!hit) begin
                    next_state = state_requesting;
                end
            end
            state_requesting: begin
                // accepted wins, that reply will come back no matter what
                if (accepted) begin
                    next_state = state_waiting;
                end else if (!same_line) begin
                    next_state = state_idle;
                end
            end
            state_waiting: begin
                if (fill_arrive) begin
                    next_state = state_idle;
                end
            end
            default: begin
                next_state = state_idle;
            end
        endcase
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state      <= state_idle;
            line_valid <= '0;
        end else begin
            state <= next_state;
            if (fill_write) begin
                line_valid[miss_index] <= 1'b1;
            end
        end
    end

    // miss address, accepted tag and line contents
    always_ff @(posedge clock) begin
        if (state == state_idle && !hit) begin
            miss_addr <= fetch_line;
        end
        if (accepted) begin
            miss_tag <= imem_response;
        end
        if (fill_write) begin
            line_tag[miss_index]  <= miss_addr[xlen-1 -: tag_bits];
            line_data[miss_index] <= imem_data;
        end
    end

    // a waiting miss must never be handed a second tag by the arbiter
    no_request_while_waiting: assert property (
        @(posedge clock) disable iff (reset)
        (state == state_waiting) |-> (imem_response == '0)
    ) else $error("icache got a new response while a miss was waiting");

endmodule

`default_nettype wire

// ==== hw/mem_arbiter.sv ====
/*
 data requests always win the bus, instruction fetch can starve
 replies are routed by tag; stores get a response only, never a reply
*/
`timescale 1ns/100ps
`default_nettype none

module mem_arbiter (
    input  logic                                clock,
    input  logic                                reset,
    input  fetch_pkg::bus_command_t             dmem_command,
    input  logic [fetch_pkg::xlen-1:0]          dmem_addr,
    input  logic [fetch_pkg::line_width-1:0]    dmem_data,
    input  fetch_pkg::bus_command_t             imem_command,
    input  logic [fetch_pkg::xlen-1:0]          imem_addr,
    input  logic [fetch_pkg::bus_tag_width-1:0] mem_response,
    input  logic [fetch_pkg::line_width-1:0]    mem_reply_data,
    input  logic [fetch_pkg::bus_tag_width-1:0] mem_tag,
    output fetch_pkg::bus_command_t             mem_command,
    output logic [fetch_pkg::xlen-1:0]          mem_addr,
    output logic [fetch_pkg::line_width-1:0]    mem_data,
    output logic [fetch_pkg::bus_tag_width-1:0] dmem_response,
    output logic [fetch_pkg::bus_tag_width-1:0] dmem_tag,
    output logic [fetch_pkg::line_width-1:0]    dmem_reply_data,
    output logic [fetch_pkg::bus_tag_width-1:0] imem_response,
    output logic [fetch_pkg::bus_tag_width-1:0] imem_tag,
    output logic [fetch_pkg::line_width-1:0]    imem_data
);
    import fetch_pkg::*;

    localparam int num_tags = 2 ** bus_tag_width;

    logic                data_sel;
    logic                load_accepted;
    logic [num_tags-1:0] tag_owned;
    logic [num_tags-1:0] tag_is_data;
    logic                reply_owned;
    logic                data_reply;
    logic                inst_reply;

    ////////////////////////////////////////
    // request side
    ////////////////////////////////////////

    // any data command takes the bus this cycle
    assign data_sel = (dmem_command != bus_none);

    assign mem_command = data_sel ? dmem_command : imem_command;
    assign mem_addr    = data_sel ? dmem_addr : imem_addr;
    // fetch never writes
    assign mem_data    = data_sel ? dmem_data : '0;

    // the loser sees 0 and holds its request
    assign dmem_response = data_sel ? mem_response : '0;
    assign imem_response = (!data_sel && imem_command != bus_none) ? mem_response : '0;

    ////////////////////////////////////////
    // owner table
    ////////////////////////////////////////

    // only loads produce a reply later
    assign load_accepted = (mem_command == bus_load) && (mem_response != '0);

    // clear on reply first, a same-cycle reuse of the tag then sets it again
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            tag_owned <= '0;
        end else begin
            if (mem_tag != '0) begin
                tag_owned[mem_tag] <= 1'b0;
            end
            if (load_accepted) begin
                tag_owned[mem_response] <= 1'b1;
            end
        end
    end

    // owner side, meaningful only while tag_owned is set
    always_ff @(posedge clock) begin
        if (load_accepted) begin
            tag_is_data[mem_response] <= data_sel;
        end
    end

    ////////////////////////////////////////
    // reply routing
    ////////////////////////////////////////

    assign reply_owned = (mem_tag != '0) && tag_owned[mem_tag];
    assign data_reply  = reply_owned && tag_is_data[mem_tag];
    assign inst_reply  = reply_owned && !tag_is_data[mem_tag];

    assign dmem_tag        = data_reply ? mem_tag : '0;
    assign dmem_reply_data = data_reply ? mem_reply_data : '0;
    assign imem_tag        = inst_reply ? mem_tag : '0;
    assign imem_data       = inst_reply ? mem_reply_data : '0;

    // memory must only answer tags it handed out for loads earlier
    reply_has_owner: assert property (
        @(posedge clock) disable iff (reset)
        (mem_tag != '0) |-> tag_owned[mem_tag]
    ) else $error("memory reply with tag %0d has no owner", mem_tag);

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# compile the fetch front end testbench with Verilator and run it
# exit status is 0 only when the pass line shows up in the output
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_fetch_mem -f filelist.f \
    || { echo "build failed"; exit 1; }

output="$(./obj_dir/Vtb_fetch_mem 2>&1)"
printf '%s\n' "$output"

printf '%s\n' "$output" | grep -qx '=== PASS ===' \
    && echo "simulation passed" && exit 0 \
    || { echo "simulation failed"; exit 1; }
